// ==== sim.f ====
rca_grid_pkg.sv
rca_issue_pkg.sv
rca_cfg_if.sv
rca_config_regs.sv
rca_grid_control.sv
rca_pr_grid.sv
rca_grid_wb.sv
rca_unit.sv
tb_rca_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rca testbench with verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rca_unit -f sim.f -o tb_rca_unit > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_rca_unit > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation passed" "$SIM_LOG"; then
    exit 0
else
    exit 1
fi

// ==== tb_rca_unit.sv ====
`timescale 1ns/1ps

module tb_rca_unit
    import rca_grid_pkg::*, rca_issue_pkg::*;
();

    localparam int WAIT_LIMIT = 40;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            new_request;
    rca_op_e         op;
    id_t             id;
    rca_idx_t        rca_sel;
    logic            use_fb;
    logic [2:0]      cfg_addr;
    logic [2:0]      cfg_data;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            ready;
    logic            done;
    id_t             done_id;
    logic [XLEN-1:0] rd0;
    logic [XLEN-1:0] rd1;

    // reference copy of both configuration banks
    grid_sel_t ref_mux [NUM_RCAS][NUM_GRID_MUXES];
    cell_op_e  ref_cell [NUM_RCAS][GRID_NUM_ROWS];
    logic      ref_iomux [NUM_RCAS][GRID_NUM_ROWS];
    logic      ref_inp [NUM_RCAS][GRID_NUM_ROWS];
    row_sel_t  ref_fb [NUM_RCAS][NUM_WRITE_PORTS];
    row_sel_t  ref_nfb [NUM_RCAS][NUM_WRITE_PORTS];
    logic [XLEN-1:0] model_row [GRID_NUM_ROWS];

    int              seed = 72;
    id_t             req_id = '0;
    id_t             last_id;
    logic [XLEN-1:0] got_rd0;
    logic [XLEN-1:0] got_rd1;
    id_t             got_id;

    rca_unit uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .new_request (new_request),
        .op          (op),
        .id          (id),
        .rca_sel     (rca_sel),
        .use_fb      (use_fb),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .rs1         (rs1),
        .rs2         (rs2),
        .ready       (ready),
        .done        (done),
        .done_id     (done_id),
        .rd0         (rd0),
        .rd1         (rd1)
    );

    always #5 clk = ~clk;

    // ======================================================================
    // error reporting
    // ======================================================================
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] exp);
        abort_run($sformatf("Error: time %0t, %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic expect_equal(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // ======================================================================
    // reference model
    // ======================================================================
    task automatic clear_reference();
        for (int k = 0; k < NUM_RCAS; k++) begin
            for (int m = 0; m < NUM_GRID_MUXES; m++) begin
                ref_mux[k][m] = '0;
            end
            for (int r = 0; r < GRID_NUM_ROWS; r++) begin
                ref_cell[k][r]  = ADD;
                ref_iomux[k][r] = 1'b0;
                ref_inp[k][r]   = 1'b0;
            end
            for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
                ref_fb[k][p]  = '0;
                ref_nfb[k][p] = '0;
            end
        end
    endtask

    // rows below r only, everything else reads zero
    function automatic logic [XLEN-1:0] source_value(input int r, input grid_sel_t s,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        int              si;
        logic [XLEN-1:0] v;
        si = int'(s);
        v  = '0;
        if (si == 0) begin
            v = a;
        end else if (si == 1) begin
            v = b;
        end else if (si - 2 < r) begin
            v = model_row[row_sel_t'(si - 2)];
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] apply_cell(input cell_op_e kind,
                                                   input logic [XLEN-1:0] x,
                                                   input logic [XLEN-1:0] y);
        logic [XLEN-1:0] v;
        case (kind)
            SUB:     v = x - y;
            XOR:     v = x ^ y;
            AND:     v = x & y;
            default: v = x + y;
        endcase
        return v;
    endfunction

    task automatic predict_results(input rca_idx_t bank, input logic fb,
                                   input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                   output logic [XLEN-1:0] e0, output logic [XLEN-1:0] e1);
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
        row_sel_t        sel;
        for (int r = 0; r < GRID_NUM_ROWS; r++) begin
            x = source_value(r, ref_mux[bank][2*r], a, b);
            y = source_value(r, ref_mux[bank][2*r+1], a, b);
            if (ref_inp[bank][r]) begin
                model_row[r] = ref_iomux[bank][r] ? b : a;
            end else begin
                model_row[r] = apply_cell(ref_cell[bank][r], x, y);
            end
        end
        sel = fb ? ref_fb[bank][0] : ref_nfb[bank][0];
        e0  = ref_inp[bank][sel] ? '0 : model_row[sel];
        sel = fb ? ref_fb[bank][1] : ref_nfb[bank][1];
        e1  = ref_inp[bank][sel] ? '0 : model_row[sel];
    endtask

    // ======================================================================
    // request sequencing
    // ======================================================================
    task automatic send_request(input rca_op_e kind, input rca_idx_t bank, input logic fb,
                                input logic [2:0] addr, input logic [2:0] data,
                                input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        int n;
        n = 0;
        @(negedge clk);
        while (!ready) begin
            n++;
            assert (n < WAIT_LIMIT) else abort_run("Timeout: ready did not return high");
            @(negedge clk);
        end
        @(posedge clk);
        new_request <= 1'b1;
        op          <= kind;
        id          <= req_id;
        rca_sel     <= bank;
        use_fb      <= fb;
        cfg_addr    <= addr;
        cfg_data    <= data;
        rs1         <= a;
        rs2         <= b;
        last_id = req_id;
        req_id  = req_id + 4'd1;
        // accept edge
        @(posedge clk);
        new_request <= 1'b0;
    endtask

    // counts edges from accept to the done cycle
    task automatic await_done(input int exp_latency, input logic busy);
        int n;
        n = 0;
        @(negedge clk);
        while (!done) begin
            expect_equal("ready", XLEN'(ready), XLEN'(!busy));
            n++;
            assert (n < WAIT_LIMIT) else abort_run("Timeout: done did not pulse");
            @(negedge clk);
        end
        expect_equal("done latency", n, exp_latency);
        expect_equal("ready", XLEN'(ready), 32'd1);
        got_rd0 = rd0;
        got_rd1 = rd1;
        got_id  = done_id;
        @(negedge clk);
        expect_equal("done", XLEN'(done), 32'd0);
    endtask

    task automatic check_result(input logic [XLEN-1:0] e0, input logic [XLEN-1:0] e1,
                                input id_t eid);
        expect_equal("rd0", got_rd0, e0);
        expect_equal("rd1", got_rd1, e1);
        expect_equal("done_id", XLEN'(got_id), XLEN'(eid));
    endtask

    task automatic cfg_write(input rca_op_e kind, input rca_idx_t bank,
                             input logic [2:0] addr, input logic [2:0] data);
        case (kind)
            CFG_GRID_MUX:   ref_mux[bank][addr] = data;
            CFG_CELL_OP:    ref_cell[bank][addr[1:0]] = cell_op_e'(data[1:0]);
            CFG_IO_MUX:     ref_iomux[bank][addr[1:0]] = data[0];
            CFG_IO_USE:     ref_inp[bank][addr[1:0]] = data[0];
            CFG_FB_RESULT:  ref_fb[bank][addr[0]] = data[1:0];
            CFG_NFB_RESULT: ref_nfb[bank][addr[0]] = data[1:0];
            default: ;
        endcase
        send_request(kind, bank, 1'b0, addr, data, '0, '0);
        await_done(0, 1'b0);
        check_result('0, '0, last_id);
    endtask

    task automatic run_use(input rca_idx_t bank, input logic fb,
                           input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic [XLEN-1:0] e0;
        logic [XLEN-1:0] e1;
        predict_results(bank, fb, a, b, e0, e1);
        send_request(RCA_USE, bank, fb, 3'd0, 3'd0, a, b);
        await_done(3, 1'b1);
        check_result(e0, e1, last_id);
    endtask

    // ======================================================================
    // tests
    // ======================================================================
    task automatic reset_defaults();
        logic [XLEN-1:0] a;
        a = 32'h1357_2468;
        @(negedge clk);
        expect_equal("ready", XLEN'(ready), 32'd1);
        expect_equal("done", XLEN'(done), 32'd0);
        run_use(1'b0, 1'b0, a, 32'h0f0f_00ff);
        check_result(a + a, a + a, last_id);
        run_use(1'b1, 1'b1, a, 32'h0f0f_00ff);
        check_result(a + a, a + a, last_id);
    endtask

    task automatic config_acks();
        cfg_write(CFG_GRID_MUX, 1'b1, 3'd0, 3'd5);
        cfg_write(CFG_CELL_OP, 1'b1, 3'd1, 3'd1);
        cfg_write(CFG_IO_MUX, 1'b1, 3'd3, 3'd1);
        cfg_write(CFG_IO_USE, 1'b1, 3'd2, 3'd1);
        cfg_write(CFG_FB_RESULT, 1'b1, 3'd1, 3'd3);
        cfg_write(CFG_NFB_RESULT, 1'b1, 3'd0, 3'd2);
    endtask

    // rows 0 and 1 inject rs1 and rs2, rows 2 and 3 pass them on
    task automatic input_rows();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = 32'hdead_0001;
        b = 32'h0000_beef;
        cfg_write(CFG_IO_USE, 1'b0, 3'd0, 3'd1);
        cfg_write(CFG_IO_USE, 1'b0, 3'd1, 3'd1);
        cfg_write(CFG_IO_MUX, 1'b0, 3'd1, 3'd1);
        cfg_write(CFG_CELL_OP, 1'b0, 3'd2, 3'd3);
        cfg_write(CFG_GRID_MUX, 1'b0, 3'd4, 3'd2);
        cfg_write(CFG_GRID_MUX, 1'b0, 3'd5, 3'd2);
        cfg_write(CFG_CELL_OP, 1'b0, 3'd3, 3'd3);
        cfg_write(CFG_GRID_MUX, 1'b0, 3'd6, 3'd3);
        cfg_write(CFG_GRID_MUX, 1'b0, 3'd7, 3'd3);
        cfg_write(CFG_NFB_RESULT, 1'b0, 3'd0, 3'd2);
        cfg_write(CFG_NFB_RESULT, 1'b0, 3'd1, 3'd3);
        cfg_write(CFG_FB_RESULT, 1'b0, 3'd0, 3'd0);
        cfg_write(CFG_FB_RESULT, 1'b0, 3'd1, 3'd1);
        run_use(1'b0, 1'b0, a, b);
        check_result(a, b, last_id);
        // input rows picked as results read zero
        run_use(1'b0, 1'b1, a, b);
        check_result('0, '0, last_id);
    endtask

    task automatic chained_ops();
        for (int r = 0; r < GRID_NUM_ROWS; r++) begin
            cfg_write(CFG_IO_USE, 1'b1, 3'(r), 3'd0);
        end
        cfg_write(CFG_GRID_MUX, 1'b1, 3'd0, 3'd0);
        cfg_write(CFG_GRID_MUX, 1'b1, 3'd1, 3'd1);
        cfg_write(CFG_GRID_MUX, 1'b1, 3'd2, 3'd1);
        cfg_write(CFG_GRID_MUX, 1'b1, 3'd3, 3'd2);
        cfg_write(CFG_GRID_MUX, 1'b1, 3'd4, 3'd2);
        cfg_write(CFG_GRID_MUX, 1'b1, 3'd5, 3'd3);
        cfg_write(CFG_GRID_MUX, 1'b1, 3'd6, 3'd0);
        cfg_write(CFG_GRID_MUX, 1'b1, 3'd7, 3'd4);
        cfg_write(CFG_CELL_OP, 1'b1, 3'd0, 3'd0);
        cfg_write(CFG_CELL_OP, 1'b1, 3'd1, 3'd1);
        cfg_write(CFG_CELL_OP, 1'b1, 3'd2, 3'd2);
        cfg_write(CFG_CELL_OP, 1'b1, 3'd3, 3'd3);
        cfg_write(CFG_NFB_RESULT, 1'b1, 3'd0, 3'd0);
        cfg_write(CFG_NFB_RESULT, 1'b1, 3'd1, 3'd1);
        cfg_write(CFG_FB_RESULT, 1'b1, 3'd0, 3'd2);
        cfg_write(CFG_FB_RESULT, 1'b1, 3'd1, 3'd3);
        run_use(1'b1, 1'b0, 32'hf0f0_1234, 32'h0ff0_8001);
        run_use(1'b1, 1'b1, 32'hf0f0_1234, 32'h0ff0_8001);
        run_use(1'b1, 1'b0, 32'h7fff_ffff, 32'h0000_0003);
        run_use(1'b1, 1'b1, 32'h7fff_ffff, 32'h0000_0003);
    endtask

    task automatic bank_alternation();
        run_use(1'b0, 1'b0, 32'h0000_00aa, 32'h0000_0055);
        run_use(1'b1, 1'b1, 32'h1234_5678, 32'h0101_0101);
        run_use(1'b0, 1'b1, 32'h0000_00aa, 32'h0000_0055);
        run_use(1'b1, 1'b0, 32'h1234_5678, 32'h0101_0101);
        cfg_write(CFG_NFB_RESULT, 1'b1, 3'd1, 3'd3);
        cfg_write(CFG_CELL_OP, 1'b1, 3'd3, 3'd0);
        // bank 0 must be untouched by the bank 1 writes
        run_use(1'b0, 1'b0, 32'hcafe_0000, 32'h0000_f00d);
        check_result(32'hcafe_0000, 32'h0000_f00d, last_id);
        run_use(1'b1, 1'b0, 32'hcafe_0000, 32'h0000_f00d);
        run_use(1'b1, 1'b1, 32'hcafe_0000, 32'h0000_f00d);
        cfg_write(CFG_FB_RESULT, 1'b0, 3'd0, 3'd2);
        run_use(1'b1, 1'b1, 32'h8000_0001, 32'h4000_0002);
        run_use(1'b0, 1'b1, 32'h8000_0001, 32'h4000_0002);
    endtask

    task automatic random_uses();
        logic [31:0]     pick;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int i = 0; i < 20; i++) begin
            a    = $random(seed);
            b    = $random(seed);
            pick = $random(seed);
            run_use(pick[0], pick[1], a, b);
        end
    endtask

    initial begin
        arst_n      <= 1'b0;
        new_request <= 1'b0;
        op          <= CFG_GRID_MUX;
        id          <= '0;
        rca_sel     <= '0;
        use_fb      <= 1'b0;
        cfg_addr    <= '0;
        cfg_data    <= '0;
        rs1         <= '0;
        rs2         <= '0;
        clear_reference();
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        reset_defaults();
        config_acks();
        input_rows();
        chained_ops();
        bank_alternation();
        random_uses();

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== rca_unit.sv ====
`timescale 1ns/1ps

module rca_unit
    import rca_grid_pkg::*, rca_issue_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            new_request,
    input  rca_op_e         op,
    input  id_t             id,
    input  rca_idx_t        rca_sel,
    input  logic            use_fb,
    input  logic [2:0]      cfg_addr,
    input  logic [2:0]      cfg_data,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    output logic            ready,
    output logic            done,
    output id_t             done_id,
    output logic [XLEN-1:0] rd0,
    output logic [XLEN-1:0] rd1
);

    logic                     cfg_wr_en;
    rca_idx_t                 running_rca;
    logic [XLEN-1:0]          buf_rs [NUM_READ_PORTS];
    logic                     capture;
    logic                     clear_fifos;
    logic                     wb_commit;
    logic                     wb_fb;
    id_t                      wb_id;
    logic                     cfg_done;
    logic [XLEN-1:0]          head_data [GRID_NUM_ROWS];
    logic [GRID_NUM_ROWS-1:0] head_valid;
    logic [GRID_NUM_ROWS-1:0] pop;

    rca_cfg_if cfg_bus ();

    rca_config_regs u_config_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_en       (cfg_wr_en),
        .op          (op),
        .wr_rca      (rca_sel),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .running_rca (running_rca),
        .cfg         (cfg_bus.regs)
    );

    rca_grid_control u_grid_control (
        .clk         (clk),
        .arst_n      (arst_n),
        .new_request (new_request),
        .op          (op),
        .id          (id),
        .rca_sel     (rca_sel),
        .use_fb      (use_fb),
        .rs1         (rs1),
        .rs2         (rs2),
        .ready       (ready),
        .cfg_wr_en   (cfg_wr_en),
        .running_rca (running_rca),
        .buf_rs      (buf_rs),
        .capture     (capture),
        .clear_fifos (clear_fifos),
        .wb_commit   (wb_commit),
        .wb_fb       (wb_fb),
        .wb_id       (wb_id),
        .cfg_done    (cfg_done)
    );

    rca_pr_grid u_pr_grid (
        .clk         (clk),
        .arst_n      (arst_n),
        .rs_vals     (buf_rs),
        .capture     (capture),
        .clear_fifos (clear_fifos),
        .pop         (pop),
        .cfg         (cfg_bus.grid),
        .head_data   (head_data),
        .head_valid  (head_valid)
    );

    rca_grid_wb u_grid_wb (
        .clk        (clk),
        .arst_n     (arst_n),
        .head_data  (head_data),
        .head_valid (head_valid),
        .wb_commit  (wb_commit),
        .wb_fb      (wb_fb),
        .wb_id      (wb_id),
        .cfg_done   (cfg_done),
        .cfg_id     (id),
        .cfg        (cfg_bus.grid),
        .pop        (pop),
        .done       (done),
        .done_id    (done_id),
        .rd0        (rd0),
        .rd1        (rd1)
    );

endmodule

// ==== rca_grid_wb.sv ====
`timescale 1ns/1ps

module rca_grid_wb
    import rca_grid_pkg::*, rca_issue_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [XLEN-1:0]          head_data [GRID_NUM_ROWS],
    input  logic [GRID_NUM_ROWS-1:0] head_valid,
    input  logic                     wb_commit,
    input  logic                     wb_fb,
    input  id_t                      wb_id,
    input  logic                     cfg_done,
    input  id_t                      cfg_id,
    rca_cfg_if.grid                  cfg,
    output logic [GRID_NUM_ROWS-1:0] pop,
    output logic                     done,
    output id_t                      done_id,
    output logic [XLEN-1:0]          rd0,
    output logic [XLEN-1:0]          rd1
);

    row_sel_t        res_row [NUM_WRITE_PORTS];
    logic [XLEN-1:0] res_val [NUM_WRITE_PORTS];

    // result mux, input rows read as zero
    always_comb begin
        for (int j = 0; j < NUM_WRITE_PORTS; j++) begin
            res_row[j] = wb_fb ? cfg.fb_result_sel[j] : cfg.nfb_result_sel[j];
            if (head_valid[res_row[j]] && !cfg.io_inp_map[res_row[j]]) begin
                res_val[j] = head_data[res_row[j]];
            end else begin
                res_val[j] = '0;
            end
        end
    end

    // one pop per row even when both ports share it
    always_comb begin
        pop = '0;
        for (int j = 0; j < NUM_WRITE_PORTS; j++) begin
            if (wb_commit) pop[res_row[j]] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else begin
            done <= wb_commit || cfg_done;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_commit) begin
            done_id <= wb_id;
            rd0     <= res_val[0];
            rd1     <= res_val[1];
        end else if (cfg_done) begin
            done_id <= cfg_id;
            rd0     <= '0;
            rd1     <= '0;
        end
    end

endmodule

// ==== rca_pr_grid.sv ====
`timescale 1ns/1ps

module rca_pr_grid
    import rca_grid_pkg::*, rca_issue_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [XLEN-1:0]          rs_vals [NUM_READ_PORTS],
    input  logic                     capture,
    input  logic                     clear_fifos,
    input  logic [GRID_NUM_ROWS-1:0] pop,
    rca_cfg_if.grid                  cfg,
    output logic [XLEN-1:0]          head_data [GRID_NUM_ROWS],
    output logic [GRID_NUM_ROWS-1:0] head_valid
);

    logic [XLEN-1:0] row_val [GRID_NUM_ROWS];

    function automatic logic [XLEN-1:0] cell_eval(
        input cell_op_e        cop,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic [XLEN-1:0] res;
        unique case (cop)
            ADD:     res = a + b;
            SUB:     res = a - b;
            XOR:     res = a ^ b;
            AND:     res = a & b;
            default: res = '0;
        endcase
        return res;
    endfunction

    // ======================================================================
    // grid muxes and row cells, evaluated top row first
    // ======================================================================
    always_comb begin
        logic [XLEN-1:0] src [GRID_MUX_INPUTS];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int s = 0; s < GRID_MUX_INPUTS; s++) begin
            src[s] = '0;
        end
        src[0] = rs_vals[0];
        src[1] = rs_vals[1];
        for (int r = 0; r < GRID_NUM_ROWS; r++) begin
            a = '0;
            b = '0;
            // only operands and rows above this one are reachable
            for (int s = 0; s < GRID_MUX_INPUTS; s++) begin
                if (s < NUM_READ_PORTS + r) begin
                    if (cfg.grid_mux_sel[2*r] == grid_sel_t'(s)) a = src[s];
                    if (cfg.grid_mux_sel[2*r+1] == grid_sel_t'(s)) b = src[s];
                end
            end
            if (cfg.io_inp_map[r]) begin
                row_val[r] = rs_vals[cfg.io_mux_sel[r]];
            end else begin
                row_val[r] = cell_eval(cfg.cell_op[r], a, b);
            end
            src[NUM_READ_PORTS+r] = row_val[r];
        end
    end

    // ======================================================================
    // io unit result fifos
    // ======================================================================
    for (genvar r = 0; r < GRID_NUM_ROWS; r++) begin : g_io
        logic [XLEN-1:0]       mem [FIFO_DEPTH];
        logic [FIFO_PTR_W-1:0] wr_ptr;
        logic [FIFO_PTR_W-1:0] rd_ptr;
        logic [FIFO_CNT_W-1:0] count;
        logic                  push;
        logic                  do_pop;

        assign push   = capture && !cfg.io_inp_map[r] && (count != FIFO_CNT_W'(FIFO_DEPTH));
        assign do_pop = pop[r] && (count != '0);

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else if (clear_fifos) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) wr_ptr <= wr_ptr + 1'b1;
                if (do_pop) rd_ptr <= rd_ptr + 1'b1;
                count <= count + FIFO_CNT_W'(push) - FIFO_CNT_W'(do_pop);
            end
        end

        always_ff @(posedge clk) begin
            if (push && !clear_fifos) begin
                mem[wr_ptr] <= row_val[r];
            end
        end

        assign head_data[r]  = mem[rd_ptr];
        assign head_valid[r] = (count != '0);
    end

endmodule

// ==== rca_grid_control.sv ====
`timescale 1ns/1ps

module rca_grid_control
    import rca_grid_pkg::*, rca_issue_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            new_request,
    input  rca_op_e         op,
    input  id_t             id,
    input  rca_idx_t        rca_sel,
    input  logic            use_fb,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    output logic            ready,
    output logic            cfg_wr_en,
    output rca_idx_t        running_rca,
    output logic [XLEN-1:0] buf_rs [NUM_READ_PORTS],
    output logic            capture,
    output logic            clear_fifos,
    output logic            wb_commit,
    output logic            wb_fb,
    output id_t             wb_id,
    output logic            cfg_done
);

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        accept;
    logic        accept_use;

    assign accept     = new_request && (state == IDLE);
    assign accept_use = accept && (op == RCA_USE);

    assign ready       = (state == IDLE);
    assign cfg_wr_en   = accept && (op != RCA_USE);
    assign cfg_done    = cfg_wr_en;
    assign clear_fifos = accept_use;
    assign capture     = (state == CAPTURE);
    assign wb_commit   = (state == WRITEBACK);

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE:      if (accept_use) state_next = COMPUTE;
            COMPUTE:   state_next = CAPTURE;
            CAPTURE:   state_next = WRITEBACK;
            WRITEBACK: state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            running_rca <= '0;
            wb_fb       <= 1'b0;
        end else begin
            state <= state_next;
            if (accept_use) begin
                running_rca <= rca_sel;
                wb_fb       <= use_fb;
            end
        end
    end

    // operand buffer, held for the whole use
    always_ff @(posedge clk) begin
        if (accept_use) begin
            buf_rs[0] <= rs1;
            buf_rs[1] <= rs2;
            wb_id     <= id;
        end
    end

endmodule

// ==== rca_config_regs.sv ====
`timescale 1ns/1ps

module rca_config_regs
    import rca_grid_pkg::*, rca_issue_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     wr_en,
    input  rca_op_e  op,
    input  rca_idx_t wr_rca,
    input  logic [2:0] cfg_addr,
    input  logic [2:0] cfg_data,
    input  rca_idx_t running_rca,
    rca_cfg_if.regs  cfg
);

    grid_sel_t grid_mux_bank [NUM_RCAS][NUM_GRID_MUXES];
    cell_op_e  cell_op_bank [NUM_RCAS][GRID_NUM_ROWS];
    logic      io_mux_bank [NUM_RCAS][GRID_NUM_ROWS];
    logic [GRID_NUM_ROWS-1:0] io_inp_bank [NUM_RCAS];
    row_sel_t  fb_result_bank [NUM_RCAS][NUM_WRITE_PORTS];
    row_sel_t  nfb_result_bank [NUM_RCAS][NUM_WRITE_PORTS];

    row_sel_t row_addr;
    logic     port_addr;

    assign row_addr  = row_sel_t'(cfg_addr[1:0]);
    assign port_addr = cfg_addr[0];

    // ======================================================================
    // write decode
    // ======================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < NUM_RCAS; b++) begin
                for (int m = 0; m < NUM_GRID_MUXES; m++) begin
                    grid_mux_bank[b][m] <= '0;
                end
                for (int r = 0; r < GRID_NUM_ROWS; r++) begin
                    cell_op_bank[b][r] <= ADD;
                    io_mux_bank[b][r]  <= 1'b0;
                end
                io_inp_bank[b] <= '0;
                for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
                    fb_result_bank[b][p]  <= '0;
                    nfb_result_bank[b][p] <= '0;
                end
            end
        end else if (wr_en) begin
            unique case (op)
                CFG_GRID_MUX:   grid_mux_bank[wr_rca][cfg_addr] <= grid_sel_t'(cfg_data);
                CFG_CELL_OP:    cell_op_bank[wr_rca][row_addr] <= cell_op_e'(cfg_data[1:0]);
                CFG_IO_MUX:     io_mux_bank[wr_rca][row_addr] <= cfg_data[0];
                CFG_IO_USE:     io_inp_bank[wr_rca][row_addr] <= cfg_data[0];
                CFG_FB_RESULT:  fb_result_bank[wr_rca][port_addr] <= row_sel_t'(cfg_data[1:0]);
                CFG_NFB_RESULT: nfb_result_bank[wr_rca][port_addr] <= row_sel_t'(cfg_data[1:0]);
                default: ;
            endcase
        end
    end

    // ======================================================================
    // readout of the running bank
    // ======================================================================
    always_comb begin
        for (int m = 0; m < NUM_GRID_MUXES; m++) begin
            cfg.grid_mux_sel[m] = grid_mux_bank[running_rca][m];
        end
        for (int r = 0; r < GRID_NUM_ROWS; r++) begin
            cfg.cell_op[r]    = cell_op_bank[running_rca][r];
            cfg.io_mux_sel[r] = io_mux_bank[running_rca][r];
        end
        cfg.io_inp_map = io_inp_bank[running_rca];
        for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
            cfg.fb_result_sel[p]  = fb_result_bank[running_rca][p];
            cfg.nfb_result_sel[p] = nfb_result_bank[running_rca][p];
        end
    end

endmodule

// ==== rca_cfg_if.sv ====
`timescale 1ns/1ps

interface rca_cfg_if
    import rca_grid_pkg::*;
();

    // configuration of the bank that is currently running
    grid_sel_t grid_mux_sel [NUM_GRID_MUXES];
    cell_op_e  cell_op [GRID_NUM_ROWS];

    // 0 picks rs1, 1 picks rs2
    logic io_mux_sel [GRID_NUM_ROWS];

    // set bit means the row injects an operand
    logic [GRID_NUM_ROWS-1:0] io_inp_map;

    row_sel_t fb_result_sel [NUM_WRITE_PORTS];
    row_sel_t nfb_result_sel [NUM_WRITE_PORTS];

    modport regs (
        output grid_mux_sel,
        output cell_op,
        output io_mux_sel,
        output io_inp_map,
        output fb_result_sel,
        output nfb_result_sel
    );

    modport grid (
        input grid_mux_sel,
        input cell_op,
        input io_mux_sel,
        input io_inp_map,
        input fb_result_sel,
        input nfb_result_sel
    );

endinterface

// ==== rca_issue_pkg.sv ====
package rca_issue_pkg;

    localparam int XLEN = 32;

    typedef logic [3:0] id_t;

    // ======================================================================
    // request kinds from the issue stage
    // ======================================================================
    typedef enum logic [2:0] {
        CFG_GRID_MUX   = 3'd0,
        CFG_CELL_OP    = 3'd1,
        CFG_IO_MUX     = 3'd2,
        CFG_IO_USE     = 3'd3,
        CFG_FB_RESULT  = 3'd4,
        CFG_NFB_RESULT = 3'd5,
        RCA_USE        = 3'd6
    } rca_op_e;

    // ======================================================================
    // grid controller states
    // ======================================================================
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        COMPUTE   = 2'd1,
        CAPTURE   = 2'd2,
        WRITEBACK = 2'd3
    } ctrl_state_e;

endpackage

// ==== rca_grid_pkg.sv ====
package rca_grid_pkg;

    // ======================================================================
    // grid geometry
    // ======================================================================
    localparam int GRID_NUM_ROWS   = 4;
    localparam int NUM_READ_PORTS  = 2;
    localparam int NUM_WRITE_PORTS = 2;
    localparam int NUM_RCAS        = 2;
    localparam int GRID_MUX_INPUTS = NUM_READ_PORTS + GRID_NUM_ROWS;
    localparam int NUM_GRID_MUXES  = 2 * GRID_NUM_ROWS;

    // io unit result fifo
    localparam int FIFO_DEPTH = 2;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // ======================================================================
    // configuration field types
    // ======================================================================
    typedef enum logic [1:0] {
        ADD = 2'd0,
        SUB = 2'd1,
        XOR = 2'd2,
        AND = 2'd3
    } cell_op_e;

    // source select of one grid mux, 0/1 are rs1/rs2, 2+k is row k
    typedef logic [$clog2(GRID_MUX_INPUTS)-1:0] grid_sel_t;

    typedef logic [$clog2(GRID_NUM_ROWS)-1:0] row_sel_t;

    typedef logic [$clog2(NUM_RCAS)-1:0] rca_idx_t;

endpackage
